/* Makefile */
TOP := mmuTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module mipsMmu
	verilator --lint-only --timing -f src.f --top-module $(TOP)

obj_dir/V$(TOP): src.f verilog/*.sv sim/*.sv
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/mmuTb.sv */
module mmuTb import mmuPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumEntries = 16;
    localparam int IdxBits    = $clog2(NumEntries);
    localparam int WaitLimit  = 200;  // cycles per wait

    logic                    clk;
    logic                    rstN;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [VaddrWidth-1:0]   paddr;
    logic [VaddrWidth-1:0]   pwdata;
    logic [VaddrWidth-1:0]   prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    xlValid;
    logic                    xlReady;
    logic [VaddrWidth-1:0]   xlVaddr;
    logic                    xlStore;
    logic                    resValid;
    logic                    resReady;
    logic [VaddrWidth-1:0]   resPaddr;
    logic                    resCached;
    logic [ExcCodeWidth-1:0] resExc;
    logic                    resRefill;

    // stimulus table columns
    string                   rowName[$];
    logic [VaddrWidth-1:0]   rowVaddr[$];
    logic                    rowStore[$];
    logic [VaddrWidth-1:0]   rowPaddr[$];
    logic                    rowCached[$];
    logic [ExcCodeWidth-1:0] rowExc[$];
    logic                    rowRefill[$];

    int          expQ[$];  // row numbers in issue order
    int          testCount;
    int          errCount;
    logic [31:0] rngState;
    logic        collectDone;

    mipsMmu #(.numEntries(NumEntries)) dut0 (
        .clk(clk), .rstN(rstN),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .xlValid(xlValid), .xlReady(xlReady), .xlVaddr(xlVaddr), .xlStore(xlStore),
        .resValid(resValid), .resReady(resReady), .resPaddr(resPaddr),
        .resCached(resCached), .resExc(resExc), .resRefill(resRefill)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // packs pfn 25:6 then c, d, v and g
    function automatic logic [VaddrWidth-1:0] makeLo(input logic [PfnWidth-1:0] pfn,
            input logic [CacheWidth-1:0] c, input logic d, input logic v, input logic g);
        return {6'd0, pfn, c, d, v, g};
    endfunction

    function automatic logic [VaddrWidth-1:0] makeHi(input logic [Vpn2Width-1:0] vpn2,
            input logic [AsidWidth-1:0] asid);
        return {vpn2, 5'd0, asid};
    endfunction

    task automatic noteTimeout(input string what);
        errCount++;
        $display("timeout: gave up waiting for %s", what);
    endtask

    task automatic checkWord(input string name, input logic [VaddrWidth-1:0] exp,
            input logic [VaddrWidth-1:0] act);
        testCount++;
        if (act !== exp) begin
            errCount++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end else begin
            $display("ok    %s", name);
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        testCount++;
        if (act !== exp) begin
            errCount++;
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
        end else begin
            $display("ok    %s", name);
        end
    endtask

    task automatic checkXlate(input string name, input logic [VaddrWidth-1:0] expPaddr,
            input logic expCached, input logic [ExcCodeWidth-1:0] expExc, input logic expRefill,
            input logic [VaddrWidth-1:0] actPaddr, input logic actCached,
            input logic [ExcCodeWidth-1:0] actExc, input logic actRefill);
        testCount++;
        if (actPaddr !== expPaddr || actCached !== expCached || actExc !== expExc
                || actRefill !== expRefill) begin
            errCount++;
            $display("[ERROR] %s expected %s actual %s", name,
                $sformatf("paddr %h cached %b exc %0d refill %b",
                    expPaddr, expCached, expExc, expRefill),
                $sformatf("paddr %h cached %b exc %0d refill %b",
                    actPaddr, actCached, actExc, actRefill));
        end else begin
            $display("ok    %s", name);
        end
    endtask

    task automatic apbAccess(input logic write, input logic [VaddrWidth-1:0] addr,
            input logic [VaddrWidth-1:0] wdata, output logic [VaddrWidth-1:0] rdata,
            output logic err);
        int waitCnt;
        @(posedge clk);
        psel    <= 1'b1;  // setup phase
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waitCnt = 0;
        do begin
            @(negedge clk);
            waitCnt++;
        end while (!pready && waitCnt < WaitLimit);
        if (!pready) noteTimeout("pready");
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apbWrite(input logic [VaddrWidth-1:0] addr,
            input logic [VaddrWidth-1:0] data, output logic err);
        logic [VaddrWidth-1:0] unused;
        apbAccess(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input logic [VaddrWidth-1:0] addr,
            output logic [VaddrWidth-1:0] data, output logic err);
        apbAccess(1'b0, addr, '0, data, err);
    endtask

    task automatic tlbWrite(input int idx, input logic [VaddrWidth-1:0] hi,
            input logic [VaddrWidth-1:0] lo0, input logic [VaddrWidth-1:0] lo1);
        logic err;
        apbWrite(RegIndex, VaddrWidth'(idx), err);
        apbWrite(RegEntryHi, hi, err);
        apbWrite(RegEntryLo0, lo0, err);
        apbWrite(RegEntryLo1, lo1, err);
        apbWrite(RegCommand, CmdTlbWrite, err);
    endtask

    task automatic addRow(input string name, input logic [VaddrWidth-1:0] vaddr,
            input logic store, input logic [VaddrWidth-1:0] paddrExp, input logic cached,
            input logic [ExcCodeWidth-1:0] exc, input logic refill);
        rowName.push_back(name);
        rowVaddr.push_back(vaddr);
        rowStore.push_back(store);
        rowPaddr.push_back(paddrExp);
        rowCached.push_back(cached);
        rowExc.push_back(exc);
        rowRefill.push_back(refill);
    endtask

    task automatic buildTable();
        // rows 0..12 run with asid 5
        addRow("kseg0 load", 32'h8012_3456, 1'b0, 32'h0012_3456, 1'b1, ExcNone, 1'b0);
        addRow("kseg1 load", 32'hBFC0_0010, 1'b0, 32'h1FC0_0010, 1'b0, ExcNone, 1'b0);
        addRow("kseg1 store", 32'hA000_0100, 1'b1, 32'h0000_0100, 1'b0, ExcNone, 1'b0);
        addRow("even page load", 32'h0002_0ABC, 1'b0, 32'h1234_5ABC, 1'b1, ExcNone, 1'b0);
        addRow("odd page store", 32'h0002_1123, 1'b1, 32'h0ABC_D123, 1'b0, ExcNone, 1'b0);
        addRow("global even load", 32'h0040_0010, 1'b0, 32'h0077_7010, 1'b1, ExcNone, 1'b0);
        addRow("global odd load", 32'h0040_1020, 1'b0, 32'h0088_8020, 1'b1, ExcNone, 1'b0);
        addRow("store clean page", 32'h0040_1020, 1'b1, 32'h0, 1'b0, ExcMod, 1'b0);
        addRow("miss load", 32'h7FFF_F000, 1'b0, 32'h0, 1'b0, ExcTlbl, 1'b1);
        addRow("miss store", 32'hC000_2000, 1'b1, 32'h0, 1'b0, ExcTlbs, 1'b1);
        addRow("invalid load", 32'h6000_0004, 1'b0, 32'h0, 1'b0, ExcTlbl, 1'b0);
        addRow("invalid store", 32'h6000_0008, 1'b1, 32'h0, 1'b0, ExcTlbs, 1'b0);
        addRow("valid odd store", 32'h6000_1FFC, 1'b1, 32'h0004_2FFC, 1'b1, ExcNone, 1'b0);
        // rows 13..15 run with asid 6
        addRow("global other asid", 32'h0040_0010, 1'b0, 32'h0077_7010, 1'b1, ExcNone, 1'b0);
        addRow("local other asid", 32'h0002_0ABC, 1'b0, 32'h0, 1'b0, ExcTlbl, 1'b1);
        addRow("local other asid st", 32'h6000_1FFC, 1'b1, 32'h0, 1'b0, ExcTlbs, 1'b1);
    endtask

    task automatic issueRows(input int first, input int last);
        int waitCnt;
        for (int i = first; i <= last; i++) begin
            @(posedge clk);
            xlValid <= 1'b1;
            xlVaddr <= rowVaddr[i];
            xlStore <= rowStore[i];
            waitCnt = 0;
            do begin
                @(negedge clk);
                waitCnt++;
            end while (!xlReady && waitCnt < WaitLimit);
            if (xlReady) expQ.push_back(i);  // taken on the next edge
            else noteTimeout("xlReady");
        end
        @(posedge clk);
        xlValid <= 1'b0;
    endtask

    task automatic collectResults(input int total);
        int got;
        int idle;
        int idx;
        got  = 0;
        idle = 0;
        while (got < total && idle < WaitLimit) begin
            @(negedge clk);
            if (resValid && resReady) begin
                if (expQ.size() == 0) begin
                    errCount++;
                    $display("a result came out with no request waiting for it");
                end else begin
                    idx = expQ.pop_front();
                    checkXlate(rowName[idx], rowPaddr[idx], rowCached[idx], rowExc[idx],
                        rowRefill[idx], resPaddr, resCached, resExc, resRefill);
                end
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got < total) noteTimeout("translation results");
        collectDone = 1'b1;
    endtask

    task automatic driveReady(input bit randomReady);
        int cyc;
        cyc = 0;
        while (!collectDone && cyc < 4 * WaitLimit) begin
            @(posedge clk);
            if (randomReady) begin
                rngState = xorshift(rngState);
                resReady <= rngState[0];
            end else begin
                resReady <= 1'b1;
            end
            cyc++;
        end
        resReady <= 1'b1;
    endtask

    task automatic runRows(input int first, input int last, input bit randomReady);
        collectDone = 1'b0;
        expQ.delete();
        fork
            issueRows(first, last);
            collectResults(last - first + 1);
            driveReady(randomReady);
        join
        @(negedge clk);
        if (resValid) begin
            errCount++;
            $display("result stream still valid after every issued request was answered");
        end
    endtask

    initial begin
        logic [VaddrWidth-1:0] rd;
        logic                  err;
        rstN      = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        xlValid   = 1'b0;
        xlVaddr   = '0;
        xlStore   = 1'b0;
        resReady  = 1'b1;
        rngState  = 32'hd52a8fa1;
        testCount = 0;
        errCount  = 0;
        buildTable();
        repeat (10) @(posedge clk);
        rstN <= 1'b1;

        // unused register bits read back as zero
        apbWrite(RegEntryLo0, 32'hFFFF_FFFF, err);
        apbWrite(RegEntryLo1, 32'hA5A5_A5A5, err);
        apbWrite(RegEntryHi, 32'hFFFF_FFFF, err);
        apbWrite(RegIndex, 32'hFFFF_FFFF, err);
        apbRead(RegEntryLo0, rd, err);
        checkWord("entryLo0 readback", 32'h03FF_FFFF, rd);
        checkFlag("entryLo0 no pslverr", 1'b0, err);
        apbRead(RegEntryLo1, rd, err);
        checkWord("entryLo1 readback", 32'h01A5_A5A5, rd);
        apbRead(RegEntryHi, rd, err);
        checkWord("entryHi readback", 32'hFFFF_E0FF, rd);
        apbRead(RegIndex, rd, err);
        checkWord("index readback", 32'h8000_0000 | 32'((1 << IdxBits) - 1), rd);
        apbRead(RegCommand, rd, err);
        checkWord("command reads zero", 32'h0, rd);
        apbWrite(32'h20, 32'h1234_5678, err);
        checkFlag("write 0x20 pslverr", 1'b1, err);
        apbRead(32'h20, rd, err);
        checkFlag("read 0x20 pslverr", 1'b1, err);
        checkWord("read 0x20 data", 32'h0, rd);
        apbRead(RegIndex, rd, err);
        checkWord("index after bad write", 32'h8000_0000 | 32'((1 << IdxBits) - 1), rd);

        tlbWrite(0, makeHi(19'h00010, 8'd5), makeLo(20'h12345, 3'd3, 1'b1, 1'b1, 1'b0),
            makeLo(20'h0ABCD, 3'd2, 1'b1, 1'b1, 1'b0));
        tlbWrite(3, makeHi(19'h00200, 8'd9), makeLo(20'h00777, 3'd3, 1'b1, 1'b1, 1'b1),
            makeLo(20'h00888, 3'd3, 1'b0, 1'b1, 1'b1));
        tlbWrite(7, makeHi(19'h30000, 8'd5), makeLo(20'h55555, 3'd3, 1'b1, 1'b0, 1'b0),
            makeLo(20'h00042, 3'd3, 1'b1, 1'b1, 1'b0));
        apbWrite(RegEntryHi, makeHi(19'h0, 8'd5), err);

        runRows(0, 2, 1'b0);   // unmapped
        runRows(3, 6, 1'b0);   // mapped hits
        runRows(7, 12, 1'b0);  // exceptions
        apbWrite(RegEntryHi, makeHi(19'h0, 8'd6), err);
        runRows(13, 15, 1'b0);

        // probe hit then miss
        apbWrite(RegIndex, 32'h8000_0002, err);
        apbWrite(RegEntryHi, makeHi(19'h30000, 8'd5), err);
        apbWrite(RegCommand, CmdTlbProbe, err);
        apbRead(RegIndex, rd, err);
        checkWord("probe hit index", 32'd7, rd);
        checkFlag("probe hit bit 31", 1'b0, rd[31]);
        apbWrite(RegEntryHi, makeHi(19'h12345, 8'd5), err);
        apbWrite(RegCommand, CmdTlbProbe, err);
        apbRead(RegIndex, rd, err);
        checkFlag("probe miss bit 31", 1'b1, rd[31]);
        checkWord("probe miss keeps index", 32'h8000_0007, rd);

        runRows(0, 12, 1'b1);  // back-pressure run under asid 5

        $display("tests: %0d, errors: %0d", testCount, errCount);
        if (errCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
verilog/mmuPkg.sv
verilog/cp0TlbRegs.sv
verilog/tlbArray.sv
verilog/addrTranslate.sv
verilog/mipsMmu.sv
sim/mmuTb.sv

/* verilog/addrTranslate.sv */
module addrTranslate import mmuPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    xlValid,
    input  logic [VaddrWidth-1:0]   xlVaddr,
    input  logic                    xlStore,
    input  logic                    lookupHit,
    input  logic [PfnWidth-1:0]     lookupPfn,
    input  logic [CacheWidth-1:0]   lookupC,
    input  logic                    lookupD,
    input  logic                    lookupV,
    input  logic                    resReady,
    output logic                    xlReady,
    output logic [Vpn2Width-1:0]    lookupVpn2,
    output logic                    lookupOdd,
    output logic                    resValid,
    output logic [VaddrWidth-1:0]   resPaddr,
    output logic                    resCached,
    output logic [ExcCodeWidth-1:0] resExc,
    output logic                    resRefill
);

    vaddrU                   va;
    logic                    accept;
    logic                    unmapped;
    logic [ExcCodeWidth-1:0] missExc;
    logic [VaddrWidth-1:0]   nxtPaddr;
    logic                    nxtCached;
    logic [ExcCodeWidth-1:0] nxtExc;
    logic                    nxtRefill;

    assign va = xlVaddr;

    assign lookupVpn2 = va.mapped.vpn2;
    assign lookupOdd  = va.mapped.oddPage;

    assign xlReady = !resValid || resReady;
    assign accept  = xlValid && xlReady;

    assign unmapped = (va.seg.segment == SegKseg0) || (va.seg.segment == SegKseg1);
    assign missExc  = xlStore ? ExcTlbs : ExcTlbl;

    always_comb begin
        nxtPaddr  = '0;
        nxtCached = 1'b0;
        nxtExc    = ExcNone;
        nxtRefill = 1'b0;
        if (unmapped) begin
            nxtPaddr  = {{SegWidth{1'b0}}, va.seg.segOffset};
            nxtCached = (va.seg.segment == SegKseg0);  // kseg0 fixed cached
        end else if (!lookupHit) begin
            nxtExc    = missExc;
            nxtRefill = 1'b1;  // refill vector
        end else if (!lookupV) begin
            nxtExc = missExc;
        end else if (xlStore && !lookupD) begin
            nxtExc = ExcMod;
        end else begin
            nxtPaddr  = {lookupPfn, va.mapped.pageOffset};
            nxtCached = (lookupC == CacheCached);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else if (accept) begin
            resValid <= 1'b1;
        end else if (resReady) begin
            resValid <= 1'b0;
        end
    end

    // result held until taken
    always_ff @(posedge clk) begin
        if (accept) begin
            resPaddr  <= nxtPaddr;
            resCached <= nxtCached;
            resExc    <= nxtExc;
            resRefill <= nxtRefill;
        end
    end

    resHold: assert property (@(posedge clk) disable iff (!rstN)
        resValid && !resReady |=> resValid && $stable(resPaddr) && $stable(resCached)
            && $stable(resExc) && $stable(resRefill))
        else $error("result changed under back-pressure");

endmodule

/* verilog/cp0TlbRegs.sv */
module cp0TlbRegs import mmuPkg::*; #(
    parameter int numEntries = 16,
    localparam int idxWidth = (numEntries > 1) ? $clog2(numEntries) : 1
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [VaddrWidth-1:0] paddr,
    input  logic [VaddrWidth-1:0] pwdata,
    input  logic                  probeHit,
    input  logic [idxWidth-1:0]   probeIndex,
    output logic [VaddrWidth-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  tlbWe,
    output logic [idxWidth-1:0]   tlbWrIndex,
    output logic [VaddrWidth-1:0] entryHi,
    output logic [VaddrWidth-1:0] entryLo0,
    output logic [VaddrWidth-1:0] entryLo1
);

    logic                  access;
    logic                  regHit;
    logic                  wrEn;
    logic                  cmdWrite;
    logic                  probeCmd;
    logic                  probeFail;
    logic [idxWidth-1:0]   idxField;
    logic [LoWidth-1:0]    lo0;
    logic [LoWidth-1:0]    lo1;
    logic [Vpn2Width-1:0]  hiVpn2;
    logic [AsidWidth-1:0]  hiAsid;
    logic [VaddrWidth-1:0] indexWord;

    assign access = psel & penable;
    assign regHit = paddr inside {RegIndex, RegEntryLo0, RegEntryLo1, RegEntryHi, RegCommand};

    assign pready  = access;  // no wait states
    assign pslverr = access & ~regHit;

    assign wrEn     = access & pwrite & regHit;
    assign cmdWrite = wrEn & (paddr == RegCommand);
    assign tlbWe    = cmdWrite & (pwdata == CmdTlbWrite);
    assign probeCmd = cmdWrite & (pwdata == CmdTlbProbe);  // other values dropped

    assign tlbWrIndex = idxField;

    // register views, unused bits tied low
    assign indexWord = {probeFail, {(IndexPBit - idxWidth){1'b0}}, idxField};
    assign entryHi   = {hiVpn2, {(HiVpn2Lsb - AsidWidth){1'b0}}, hiAsid};
    assign entryLo0  = {{(VaddrWidth - LoWidth){1'b0}}, lo0};
    assign entryLo1  = {{(VaddrWidth - LoWidth){1'b0}}, lo1};

    always_comb begin
        case (paddr)
            RegIndex:    prdata = indexWord;
            RegEntryLo0: prdata = entryLo0;
            RegEntryLo1: prdata = entryLo1;
            RegEntryHi:  prdata = entryHi;
            default:     prdata = '0;  // command reg and holes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            probeFail <= 1'b0;
            idxField  <= '0;
            lo0       <= '0;
            lo1       <= '0;
            hiVpn2    <= '0;
            hiAsid    <= '0;
        end else if (wrEn) begin
            case (paddr)
                RegIndex: begin
                    probeFail <= pwdata[IndexPBit];
                    idxField  <= pwdata[idxWidth-1:0];
                end
                RegEntryLo0: lo0 <= pwdata[LoWidth-1:0];
                RegEntryLo1: lo1 <= pwdata[LoWidth-1:0];
                RegEntryHi: begin
                    hiVpn2 <= pwdata[HiVpn2Lsb +: Vpn2Width];
                    hiAsid <= pwdata[AsidWidth-1:0];
                end
                default: ;
            endcase

            // probe result lands in Index on the access edge
            if (probeCmd) begin
                if (probeHit) begin
                    probeFail <= 1'b0;
                    idxField  <= probeIndex;
                end else begin
                    probeFail <= 1'b1;  // index kept
                end
            end
        end
    end

    // every access phase follows a setup phase
    apbPhaseOrder: assert property (@(posedge clk) disable iff (!rstN)
        penable |-> psel && $past(psel && !penable))
        else $error("apb access phase without setup");

endmodule

/* verilog/mipsMmu.sv */
module mipsMmu import mmuPkg::*; #(
    parameter int numEntries = 16,
    localparam int idxWidth = (numEntries > 1) ? $clog2(numEntries) : 1
) (
    input  logic                    clk,
    input  logic                    rstN,
    // apb slave
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [VaddrWidth-1:0]   paddr,
    input  logic [VaddrWidth-1:0]   pwdata,
    output logic [VaddrWidth-1:0]   prdata,
    output logic                    pready,
    output logic                    pslverr,
    // request stream
    input  logic                    xlValid,
    output logic                    xlReady,
    input  logic [VaddrWidth-1:0]   xlVaddr,
    input  logic                    xlStore,
    // result stream
    output logic                    resValid,
    input  logic                    resReady,
    output logic [VaddrWidth-1:0]   resPaddr,
    output logic                    resCached,
    output logic [ExcCodeWidth-1:0] resExc,
    output logic                    resRefill
);

    logic                  tlbWe;
    logic [idxWidth-1:0]   tlbWrIndex;
    logic [VaddrWidth-1:0] entryHi;
    logic [VaddrWidth-1:0] entryLo0;
    logic [VaddrWidth-1:0] entryLo1;
    logic                  probeHit;
    logic [idxWidth-1:0]   probeIndex;
    logic [Vpn2Width-1:0]  lookupVpn2;
    logic                  lookupOdd;
    logic                  lookupHit;
    logic [PfnWidth-1:0]   lookupPfn;
    logic [CacheWidth-1:0] lookupC;
    logic                  lookupD;
    logic                  lookupV;

    cp0TlbRegs #(.numEntries(numEntries)) uCp0Regs (
        .clk(clk), .rstN(rstN),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .probeHit(probeHit), .probeIndex(probeIndex),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .tlbWe(tlbWe), .tlbWrIndex(tlbWrIndex),
        .entryHi(entryHi), .entryLo0(entryLo0), .entryLo1(entryLo1)
    );

    tlbArray #(.numEntries(numEntries)) uTlb (
        .clk(clk), .rstN(rstN),
        .tlbWe(tlbWe), .tlbWrIndex(tlbWrIndex),
        .entryHi(entryHi), .entryLo0(entryLo0), .entryLo1(entryLo1),
        .lookupVpn2(lookupVpn2), .lookupOdd(lookupOdd),
        .lookupHit(lookupHit), .lookupPfn(lookupPfn), .lookupC(lookupC),
        .lookupD(lookupD), .lookupV(lookupV),
        .probeHit(probeHit), .probeIndex(probeIndex)
    );

    addrTranslate uXlate (
        .clk(clk), .rstN(rstN),
        .xlValid(xlValid), .xlVaddr(xlVaddr), .xlStore(xlStore), .xlReady(xlReady),
        .lookupHit(lookupHit), .lookupPfn(lookupPfn), .lookupC(lookupC),
        .lookupD(lookupD), .lookupV(lookupV),
        .lookupVpn2(lookupVpn2), .lookupOdd(lookupOdd),
        .resReady(resReady), .resValid(resValid), .resPaddr(resPaddr),
        .resCached(resCached), .resExc(resExc), .resRefill(resRefill)
    );

endmodule

/* verilog/mmuPkg.sv */
package mmuPkg;

    // basic widths
    localparam int VaddrWidth      = 32;  // addresses and apb data
    localparam int Vpn2Width       = 19;
    localparam int PfnWidth        = 20;
    localparam int AsidWidth       = 8;
    localparam int CacheWidth      = 3;
    localparam int ExcCodeWidth    = 5;
    localparam int PageOffsetWidth = 12;
    localparam int SegWidth        = 3;

    // EntryLo layout: pfn | c | d | v | g
    localparam int LoGBit   = 0;
    localparam int LoVBit   = 1;
    localparam int LoDBit   = 2;
    localparam int LoCLsb   = 3;
    localparam int LoPfnLsb = 6;
    localparam int LoWidth  = LoPfnLsb + PfnWidth;

    localparam int HiVpn2Lsb = 13;  // EntryHi vpn2 position
    localparam int IndexPBit = 31;  // probe failed flag

    localparam logic [CacheWidth-1:0] CacheCached = 3'd3;

    localparam logic [ExcCodeWidth-1:0] ExcNone = 5'd0;
    localparam logic [ExcCodeWidth-1:0] ExcMod  = 5'd1;
    localparam logic [ExcCodeWidth-1:0] ExcTlbl = 5'd2;
    localparam logic [ExcCodeWidth-1:0] ExcTlbs = 5'd3;

    // apb register map
    localparam logic [VaddrWidth-1:0] RegIndex    = 32'h00;
    localparam logic [VaddrWidth-1:0] RegEntryLo0 = 32'h04;
    localparam logic [VaddrWidth-1:0] RegEntryLo1 = 32'h08;
    localparam logic [VaddrWidth-1:0] RegEntryHi  = 32'h0C;
    localparam logic [VaddrWidth-1:0] RegCommand  = 32'h10;

    localparam logic [VaddrWidth-1:0] CmdTlbWrite = 32'd1;
    localparam logic [VaddrWidth-1:0] CmdTlbProbe = 32'd2;

    localparam logic [SegWidth-1:0] SegKseg0 = 3'b100;
    localparam logic [SegWidth-1:0] SegKseg1 = 3'b101;

    // same 32 bits, seen as a tlb page or as a segment
    typedef union packed {
        struct packed {
            logic [Vpn2Width-1:0]       vpn2;
            logic                       oddPage;
            logic [PageOffsetWidth-1:0] pageOffset;
        } mapped;
        struct packed {
            logic [SegWidth-1:0]            segment;
            logic [VaddrWidth-SegWidth-1:0] segOffset;
        } seg;
    } vaddrU;

endpackage

/* verilog/tlbArray.sv */
module tlbArray import mmuPkg::*; #(
    parameter int numEntries = 16,
    localparam int idxWidth = (numEntries > 1) ? $clog2(numEntries) : 1
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  tlbWe,
    input  logic [idxWidth-1:0]   tlbWrIndex,
    input  logic [VaddrWidth-1:0] entryHi,
    input  logic [VaddrWidth-1:0] entryLo0,
    input  logic [VaddrWidth-1:0] entryLo1,
    input  logic [Vpn2Width-1:0]  lookupVpn2,
    input  logic                  lookupOdd,
    output logic                  lookupHit,
    output logic [PfnWidth-1:0]   lookupPfn,
    output logic [CacheWidth-1:0] lookupC,
    output logic                  lookupD,
    output logic                  lookupV,
    output logic                  probeHit,
    output logic [idxWidth-1:0]   probeIndex
);

    logic [numEntries-1:0]   entryVld;
    logic [Vpn2Width-1:0]    vpn2Mem [numEntries];
    logic [AsidWidth-1:0]    asidMem [numEntries];
    logic                    gMem    [numEntries];
    logic [LoWidth-1:LoVBit] pageMem [numEntries][2];  // pfn, c, d, v per half

    logic [AsidWidth-1:0]    curAsid;
    logic [numEntries-1:0]   lkMatch;
    logic [numEntries-1:0]   prMatch;
    logic [idxWidth-1:0]     lkIdx;
    logic [LoWidth-1:LoVBit] lkPage;

    assign curAsid = entryHi[AsidWidth-1:0];

    function automatic logic [numEntries-1:0] matchVec(input logic [Vpn2Width-1:0] vpn2);
        logic [numEntries-1:0] m;
        for (int i = 0; i < numEntries; i++) begin
            m[i] = entryVld[i] && (vpn2Mem[i] == vpn2) && (gMem[i] || asidMem[i] == curAsid);
        end
        return m;
    endfunction

    function automatic logic [idxWidth-1:0] encode(input logic [numEntries-1:0] m);
        logic [idxWidth-1:0] idx;
        idx = '0;
        for (int i = 0; i < numEntries; i++) begin
            if (m[i]) idx = idx | idxWidth'(i);  // exact for a one-hot vector
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            entryVld <= '0;
        end else if (tlbWe) begin
            entryVld[tlbWrIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbWe) begin
            vpn2Mem[tlbWrIndex]    <= entryHi[HiVpn2Lsb +: Vpn2Width];
            asidMem[tlbWrIndex]    <= curAsid;
            gMem[tlbWrIndex]       <= entryLo0[LoGBit] & entryLo1[LoGBit];
            pageMem[tlbWrIndex][0] <= entryLo0[LoWidth-1:LoVBit];
            pageMem[tlbWrIndex][1] <= entryLo1[LoWidth-1:LoVBit];
        end
    end

    // translation port
    always_comb begin
        lkMatch = matchVec(lookupVpn2);
        lkIdx   = encode(lkMatch);
        lkPage  = pageMem[lkIdx][lookupOdd];
    end

    assign lookupHit = |lkMatch;
    assign lookupPfn = lkPage[LoPfnLsb +: PfnWidth];
    assign lookupC   = lkPage[LoCLsb +: CacheWidth];
    assign lookupD   = lkPage[LoDBit];
    assign lookupV   = lkPage[LoVBit];

    // probe port, keyed by EntryHi
    always_comb begin
        prMatch    = matchVec(entryHi[HiVpn2Lsb +: Vpn2Width]);
        probeIndex = encode(prMatch);
    end

    assign probeHit = |prMatch;

    singleMatch: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(lkMatch) && $onehot0(prMatch))
        else $error("multiple tlb entries match");

endmodule
